// File: logic/rr_csr_defs.svh
`ifndef RR_CSR_DEFS_SVH
`define RR_CSR_DEFS_SVH

// Register file geometry
`define RR_CSR_CNT              16
`define RR_CSR_IDX_W            4
`define RR_REG_STAGES           1
`define RR_CSR_VERSION_WORD     32'h0001_0002

// Register indices, one 32-bit word each
`define RR_CSR_VERSION              4'd0
`define RR_CSR_MODE                 4'd1
`define RR_CSR_BUF_ADDR_LO          4'd2
`define RR_CSR_BUF_ADDR_HI          4'd3
`define RR_CSR_BUF_SIZE_LO          4'd4
`define RR_CSR_BUF_SIZE_HI          4'd5
`define RR_CSR_RECORD_BUF_UPDATE    4'd6
`define RR_CSR_REPLAY_BUF_UPDATE    4'd7
`define RR_CSR_RECORD_FORCE_FINISH  4'd8
`define RR_CSR_VALIDATE_BUF_UPDATE  4'd9
`define RR_CSR_REPLAY_BITS_LO       4'd10
`define RR_CSR_REPLAY_BITS_HI       4'd11
`define RR_CSR_RECORD_BITS_LO       4'd12
`define RR_CSR_RECORD_BITS_HI       4'd13
`define RR_CSR_VALIDATE_BITS_LO     4'd14
`define RR_CSR_VALIDATE_BITS_HI     4'd15

`endif

// File: logic/rr_csr_pkg.sv
`include "rr_csr_defs.svh"

package rr_csr_pkg;

    typedef logic [31:0]                csr_word_t;
    typedef logic [`RR_CSR_IDX_W-1:0]   csr_idx_t;
    typedef logic [31:0]                axil_addr_t;
    typedef logic [3:0]                 axil_strb_t;
    typedef logic [63:0]                bit_count_t;
    typedef logic [7:0]                 beat_bits_t;

    // MODE register bits 0 to 2
    typedef struct packed {
        logic validate_en;
        logic replay_en;
        logic record_en;
    } rr_mode_t;

    typedef struct packed {
        logic [63:0] buf_addr;
        logic [63:0] buf_size;
        bit_count_t  replay_bits;
        logic        write_buf_update;
        logic        read_buf_update;
        logic        record_force_finish;
        logic        validate_buf_update;
    } storage_ctrl_t;

    typedef struct packed {
        bit_count_t record_bits;
        bit_count_t validate_bits;
    } storage_stats_t;

endpackage

// File: logic/rr_axil_if.sv
interface rr_axil_if;
    import rr_csr_pkg::*;

    // Write address and write data
    logic       awvalid;
    logic       awready;
    axil_addr_t awaddr;
    logic       wvalid;
    logic       wready;
    csr_word_t  wdata;
    axil_strb_t wstrb;

    // Write response
    logic       bvalid;
    logic       bready;
    logic [1:0] bresp;

    // Read address and read data
    logic       arvalid;
    logic       arready;
    axil_addr_t araddr;
    logic       rvalid;
    logic       rready;
    csr_word_t  rdata;
    logic [1:0] rresp;

    modport master (
        output awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
        input  awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
    );

    modport slave (
        input  awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
        output awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
    );

endinterface

// File: logic/rr_pipe.sv
module rr_pipe #(
    parameter int WIDTH  = 1,
    parameter int STAGES = 1
) (
    input  logic             clk,
    input  logic             rstn,
    input  logic [WIDTH-1:0] in_i,
    output logic [WIDTH-1:0] out_o
);

    if (STAGES == 0) begin : g_wire
        assign out_o = in_i;
    end else begin : g_regs
        logic [WIDTH-1:0] stage_q [STAGES];

        // Shift register, stage 0 nearest the input
        always_ff @(posedge clk) begin
            if (!rstn) begin
                for (int i = 0; i < STAGES; i++) begin
                    stage_q[i] <= '0;
                end
            end else begin
                stage_q[0] <= in_i;
                for (int i = 1; i < STAGES; i++) begin
                    stage_q[i] <= stage_q[i-1];
                end
            end
        end

        assign out_o = stage_q[STAGES-1];
    end

endmodule

// File: logic/rr_csrs.sv
`include "rr_csr_defs.svh"

module rr_csrs #(
    parameter int REG_STAGES = `RR_REG_STAGES
) (
    input  logic                       clk,
    input  logic                       rstn,
    rr_axil_if.slave                   bus,
    input  rr_csr_pkg::storage_stats_t stats_i,
    output rr_csr_pkg::storage_ctrl_t  ctrl_o,
    output rr_csr_pkg::rr_mode_t       mode_o
);
    import rr_csr_pkg::*;

    csr_word_t      csrs [`RR_CSR_CNT];

    logic           aw_fire;
    logic           w_fire;
    logic           wr_fire;
    logic           aw_held;
    logic           w_held;
    logic           wr_q;
    logic           wr_qq;
    logic           b_stall;
    logic           r_stall;
    logic           ar_fire;
    csr_idx_t       wr_idx;
    csr_idx_t       commit_idx;
    csr_idx_t       rd_idx;
    csr_word_t      wr_data;
    csr_word_t      wr_mask;
    csr_word_t      merge_base;
    csr_word_t      merge_q;
    storage_stats_t stats_q;
    storage_ctrl_t  ctrl_d;
    rr_mode_t       mode_d;

    function automatic logic is_read_only(csr_idx_t idx);
        return (idx == `RR_CSR_VERSION) || (idx == `RR_CSR_RECORD_BITS_LO) ||
               (idx == `RR_CSR_RECORD_BITS_HI) || (idx == `RR_CSR_VALIDATE_BITS_LO) ||
               (idx == `RR_CSR_VALIDATE_BITS_HI);
    endfunction

    // Write channels, either may come first
    assign aw_fire     = bus.awvalid & bus.awready;
    assign w_fire      = bus.wvalid & bus.wready;
    assign wr_fire     = (aw_fire | aw_held) & (w_fire | w_held);
    assign b_stall     = bus.bvalid & ~bus.bready;
    assign bus.awready = ~aw_held & ~b_stall;
    assign bus.wready  = ~w_held & ~b_stall;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            wr_q    <= 1'b0;
            wr_qq   <= 1'b0;
        end else begin
            aw_held <= (aw_held | aw_fire) & ~wr_fire;
            w_held  <= (w_held | w_fire) & ~wr_fire;
            wr_q    <= wr_fire;
            wr_qq   <= wr_q;
        end
    end

    // Word index from the byte address, strobes widened to a bit mask
    always_ff @(posedge clk) begin
        if (aw_fire) begin
            wr_idx <= bus.awaddr[2 +: `RR_CSR_IDX_W];
        end
        if (w_fire) begin
            wr_data <= bus.wdata;
            for (int b = 0; b < 4; b++) begin
                wr_mask[8*b +: 8] <= {8{bus.wstrb[b]}};
            end
        end
    end

    // Back-to-back writes to one index see the word still being committed
    assign merge_base = (wr_qq && commit_idx == wr_idx) ? merge_q : csrs[wr_idx];

    always_ff @(posedge clk) begin
        if (wr_q) begin
            merge_q    <= (wr_data & wr_mask) | (merge_base & ~wr_mask);
            commit_idx <= wr_idx;
        end
    end

    rr_pipe #(
        .WIDTH  ($bits(storage_stats_t)),
        .STAGES (REG_STAGES)
    ) u_stats_pipe (
        .clk   (clk),
        .rstn  (rstn),
        .in_i  (stats_i),
        .out_o (stats_q)
    );

    // Register file; read-only words are refreshed every cycle
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < `RR_CSR_CNT; i++) begin
                csrs[i] <= '0;
            end
        end else begin
            if (wr_qq && !is_read_only(commit_idx)) begin
                csrs[commit_idx] <= merge_q;
            end
            csrs[`RR_CSR_VERSION]          <= `RR_CSR_VERSION_WORD;
            csrs[`RR_CSR_RECORD_BITS_LO]   <= stats_q.record_bits[31:0];
            csrs[`RR_CSR_RECORD_BITS_HI]   <= stats_q.record_bits[63:32];
            csrs[`RR_CSR_VALIDATE_BITS_LO] <= stats_q.validate_bits[31:0];
            csrs[`RR_CSR_VALIDATE_BITS_HI] <= stats_q.validate_bits[63:32];
        end
    end

    // Write response, held until bready
    always_ff @(posedge clk) begin
        if (!rstn) begin
            bus.bvalid <= 1'b0;
        end else if (wr_fire) begin
            bus.bvalid <= 1'b1;
        end else if (bus.bready) begin
            bus.bvalid <= 1'b0;
        end
    end

    assign bus.bresp = 2'b00;

    // Reads wait out a pending response and the two commit cycles
    assign r_stall     = bus.rvalid & ~bus.rready;
    assign bus.arready = ~r_stall & ~wr_q & ~wr_qq;
    assign ar_fire     = bus.arvalid & bus.arready;
    assign rd_idx      = bus.araddr[2 +: `RR_CSR_IDX_W];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            bus.rvalid <= 1'b0;
        end else if (ar_fire) begin
            bus.rvalid <= 1'b1;
        end else if (bus.rready) begin
            bus.rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            bus.rdata <= csrs[rd_idx];
        end
    end

    assign bus.rresp = 2'b00;

    // Command pulses come from the committed index, one cycle per write
    assign ctrl_d.buf_addr            = {csrs[`RR_CSR_BUF_ADDR_HI], csrs[`RR_CSR_BUF_ADDR_LO]};
    assign ctrl_d.buf_size            = {csrs[`RR_CSR_BUF_SIZE_HI], csrs[`RR_CSR_BUF_SIZE_LO]};
    assign ctrl_d.replay_bits         = {csrs[`RR_CSR_REPLAY_BITS_HI],
                                         csrs[`RR_CSR_REPLAY_BITS_LO]};
    assign ctrl_d.write_buf_update    = wr_qq && (commit_idx == `RR_CSR_RECORD_BUF_UPDATE);
    assign ctrl_d.read_buf_update     = wr_qq && (commit_idx == `RR_CSR_REPLAY_BUF_UPDATE);
    assign ctrl_d.record_force_finish = wr_qq && (commit_idx == `RR_CSR_RECORD_FORCE_FINISH);
    assign ctrl_d.validate_buf_update = wr_qq && (commit_idx == `RR_CSR_VALIDATE_BUF_UPDATE);

    assign mode_d.record_en   = csrs[`RR_CSR_MODE][0];
    assign mode_d.replay_en   = csrs[`RR_CSR_MODE][1];
    assign mode_d.validate_en = csrs[`RR_CSR_MODE][2];

    rr_pipe #(
        .WIDTH  ($bits(storage_ctrl_t)),
        .STAGES (REG_STAGES)
    ) u_ctrl_pipe (
        .clk   (clk),
        .rstn  (rstn),
        .in_i  (ctrl_d),
        .out_o (ctrl_o)
    );

    rr_pipe #(
        .WIDTH  ($bits(rr_mode_t)),
        .STAGES (REG_STAGES)
    ) u_mode_pipe (
        .clk   (clk),
        .rstn  (rstn),
        .in_i  (mode_d),
        .out_o (mode_o)
    );

endmodule

// File: logic/rr_trace_stats.sv
module rr_trace_stats (
    input  logic                       clk,
    input  logic                       rstn,
    input  rr_csr_pkg::storage_ctrl_t  ctrl_i,
    input  rr_csr_pkg::rr_mode_t       mode_i,
    input  logic                       trace_valid_i,
    input  rr_csr_pkg::beat_bits_t     trace_bits_i,
    input  logic                       validate_valid_i,
    input  rr_csr_pkg::beat_bits_t     validate_bits_i,
    output rr_csr_pkg::storage_stats_t stats_o
);
    import rr_csr_pkg::*;

    bit_count_t record_cnt;
    bit_count_t validate_cnt;

    // A buffer update restarts the count, otherwise add the beat when enabled
    function automatic bit_count_t next_count(bit_count_t cnt, logic clear, logic en,
                                              logic valid, beat_bits_t bits);
        bit_count_t result;
        result = cnt;
        if (clear) begin
            result = '0;
        end else if (en && valid) begin
            result = cnt + bit_count_t'(bits);
        end
        return result;
    endfunction

    always_ff @(posedge clk) begin
        if (!rstn) begin
            record_cnt   <= '0;
            validate_cnt <= '0;
        end else begin
            record_cnt   <= next_count(record_cnt, ctrl_i.write_buf_update,
                                       mode_i.record_en, trace_valid_i, trace_bits_i);
            validate_cnt <= next_count(validate_cnt, ctrl_i.validate_buf_update,
                                       mode_i.validate_en, validate_valid_i,
                                       validate_bits_i);
        end
    end

    assign stats_o.record_bits   = record_cnt;
    assign stats_o.validate_bits = validate_cnt;

endmodule

// File: logic/rr_cfg_top.sv
`include "rr_csr_defs.svh"

module rr_cfg_top #(
    parameter int REG_STAGES = `RR_REG_STAGES
) (
    input  logic                   clk,
    input  logic                   rstn,
    // AXI-Lite slave port
    input  logic                   awvalid_i,
    output logic                   awready_o,
    input  rr_csr_pkg::axil_addr_t awaddr_i,
    input  logic                   wvalid_i,
    output logic                   wready_o,
    input  rr_csr_pkg::csr_word_t  wdata_i,
    input  rr_csr_pkg::axil_strb_t wstrb_i,
    output logic                   bvalid_o,
    input  logic                   bready_i,
    output logic [1:0]             bresp_o,
    input  logic                   arvalid_i,
    output logic                   arready_o,
    input  rr_csr_pkg::axil_addr_t araddr_i,
    output logic                   rvalid_o,
    input  logic                   rready_i,
    output rr_csr_pkg::csr_word_t  rdata_o,
    output logic [1:0]             rresp_o,
    // Trace beats
    input  logic                   trace_valid_i,
    input  rr_csr_pkg::beat_bits_t trace_bits_i,
    input  logic                   validate_valid_i,
    input  rr_csr_pkg::beat_bits_t validate_bits_i,
    // Control towards the trace storage
    output rr_csr_pkg::rr_mode_t   mode_o,
    output logic [63:0]            buf_addr_o,
    output logic [63:0]            buf_size_o,
    output rr_csr_pkg::bit_count_t replay_bits_o,
    output logic                   write_buf_update_o,
    output logic                   read_buf_update_o,
    output logic                   record_force_finish_o,
    output logic                   validate_buf_update_o
);
    import rr_csr_pkg::*;

    storage_ctrl_t  ctrl;
    storage_stats_t stats;

    rr_axil_if axil ();

    assign axil.awvalid = awvalid_i;
    assign axil.awaddr  = awaddr_i;
    assign axil.wvalid  = wvalid_i;
    assign axil.wdata   = wdata_i;
    assign axil.wstrb   = wstrb_i;
    assign axil.bready  = bready_i;
    assign axil.arvalid = arvalid_i;
    assign axil.araddr  = araddr_i;
    assign axil.rready  = rready_i;

    assign awready_o = axil.awready;
    assign wready_o  = axil.wready;
    assign bvalid_o  = axil.bvalid;
    assign bresp_o   = axil.bresp;
    assign arready_o = axil.arready;
    assign rvalid_o  = axil.rvalid;
    assign rdata_o   = axil.rdata;
    assign rresp_o   = axil.rresp;

    rr_csrs #(
        .REG_STAGES (REG_STAGES)
    ) u_csrs (
        .clk     (clk),
        .rstn    (rstn),
        .bus     (axil.slave),
        .stats_i (stats),
        .ctrl_o  (ctrl),
        .mode_o  (mode_o)
    );

    rr_trace_stats u_trace_stats (
        .clk              (clk),
        .rstn             (rstn),
        .ctrl_i           (ctrl),
        .mode_i           (mode_o),
        .trace_valid_i    (trace_valid_i),
        .trace_bits_i     (trace_bits_i),
        .validate_valid_i (validate_valid_i),
        .validate_bits_i  (validate_bits_i),
        .stats_o          (stats)
    );

    assign buf_addr_o            = ctrl.buf_addr;
    assign buf_size_o            = ctrl.buf_size;
    assign replay_bits_o         = ctrl.replay_bits;
    assign write_buf_update_o    = ctrl.write_buf_update;
    assign read_buf_update_o     = ctrl.read_buf_update;
    assign record_force_finish_o = ctrl.record_force_finish;
    assign validate_buf_update_o = ctrl.validate_buf_update;

endmodule

// File: tb/rr_cfg_asserts.sv
module rr_cfg_asserts #(
    parameter int REG_STAGES = 1
) (
    input logic        clk,
    input logic        rstn,
    input logic        awvalid_i,
    input logic        awready_o,
    input logic [31:0] awaddr_i,
    input logic        wvalid_i,
    input logic        wready_o,
    input logic        bvalid_o,
    input logic        bready_i,
    input logic [1:0]  bresp_o,
    input logic        arvalid_i,
    input logic        arready_o,
    input logic        rvalid_o,
    input logic        rready_i,
    input logic [31:0] rdata_o,
    input logic [2:0]  mode_o,
    input logic        write_buf_update_o,
    input logic        read_buf_update_o,
    input logic        record_force_finish_o,
    input logic        validate_buf_update_o
);
    timeunit 1ns;
    timeprecision 1ps;

    int          fail_cnt = 0;
    logic        aw_seen;
    logic        w_seen;
    logic [3:0]  idx_q;
    logic        aw_fire;
    logic        w_fire;
    logic        wr_done;
    logic [3:0]  wr_idx;
    logic [3:0]  pulse_now;
    logic [3:0]  exp_q [REG_STAGES + 2];

    assign aw_fire   = awvalid_i & awready_o;
    assign w_fire    = wvalid_i & wready_o;
    assign wr_done   = (aw_fire | aw_seen) & (w_fire | w_seen);
    assign wr_idx    = aw_fire ? awaddr_i[5:2] : idx_q;
    assign pulse_now = {validate_buf_update_o, record_force_finish_o,
                        read_buf_update_o, write_buf_update_o};

    // Expected pulses, one bit per command index 6 to 9
    always_ff @(posedge clk) begin
        if (!rstn) begin
            aw_seen <= 1'b0;
            w_seen  <= 1'b0;
            idx_q   <= '0;
            for (int i = 0; i <= REG_STAGES + 1; i++) begin
                exp_q[i] <= '0;
            end
        end else begin
            aw_seen <= (aw_seen | aw_fire) & ~wr_done;
            w_seen  <= (w_seen | w_fire) & ~wr_done;
            if (aw_fire) idx_q <= awaddr_i[5:2];
            for (int c = 0; c < 4; c++) begin
                exp_q[0][c] <= wr_done && wr_idx == 4'(6 + c);
            end
            for (int i = 1; i <= REG_STAGES + 1; i++) begin
                exp_q[i] <= exp_q[i-1];
            end
        end
    end

    a_reset_state: assert property (@(posedge clk)
        $rose(rstn) |-> !bvalid_o && !rvalid_o && mode_o == 3'b000 && pulse_now == 4'b0000)
        else begin
            $error("Outputs not idle after reset");
            fail_cnt++;
        end

    a_aw_waits: assert property (@(posedge clk) disable iff (!rstn)
        aw_fire && !w_fire && wready_o |=> !awready_o)
        else begin
            $error("awready high while waiting for W");
            fail_cnt++;
        end

    a_w_waits: assert property (@(posedge clk) disable iff (!rstn)
        w_fire && !aw_fire && awready_o |=> !wready_o)
        else begin
            $error("wready high while waiting for AW");
            fail_cnt++;
        end

    a_b_hold: assert property (@(posedge clk) disable iff (!rstn)
        bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o))
        else begin
            $error("Write response dropped under back-pressure");
            fail_cnt++;
        end

    a_b_block: assert property (@(posedge clk) disable iff (!rstn)
        bvalid_o && !bready_i |-> !awready_o && !wready_o)
        else begin
            $error("Write channels ready while response is stalled");
            fail_cnt++;
        end

    a_r_hold: assert property (@(posedge clk) disable iff (!rstn)
        rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o))
        else begin
            $error("Read data changed under back-pressure");
            fail_cnt++;
        end

    a_r_block: assert property (@(posedge clk) disable iff (!rstn)
        rvalid_o && !rready_i |-> !arready_o)
        else begin
            $error("arready high while read data is stalled");
            fail_cnt++;
        end

    a_pulse: assert property (@(posedge clk) disable iff (!rstn)
        pulse_now == exp_q[REG_STAGES + 1])
        else begin
            $error("Command pulse wrong in timing or target");
            fail_cnt++;
        end

endmodule

bind rr_cfg_top rr_cfg_asserts #(.REG_STAGES(REG_STAGES)) u_asserts (.*);

// File: tb/rr_cfg_tb.sv
`include "rr_csr_defs.svh"

module rr_cfg_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int STAGES = `RR_REG_STAGES;

    logic        clk;
    logic        rstn;
    logic        awvalid_i;
    logic        awready_o;
    logic [31:0] awaddr_i;
    logic        wvalid_i;
    logic        wready_o;
    logic [31:0] wdata_i;
    logic [3:0]  wstrb_i;
    logic        bvalid_o;
    logic        bready_i;
    logic [1:0]  bresp_o;
    logic        arvalid_i;
    logic        arready_o;
    logic [31:0] araddr_i;
    logic        rvalid_o;
    logic        rready_i;
    logic [31:0] rdata_o;
    logic [1:0]  rresp_o;
    logic        trace_valid_i;
    logic [7:0]  trace_bits_i;
    logic        validate_valid_i;
    logic [7:0]  validate_bits_i;
    logic [2:0]  mode_o;
    logic [63:0] buf_addr_o;
    logic [63:0] buf_size_o;
    logic [63:0] replay_bits_o;
    logic        write_buf_update_o;
    logic        read_buf_update_o;
    logic        record_force_finish_o;
    logic        validate_buf_update_o;

    logic [31:0] shadow [`RR_CSR_CNT];
    int          err_cnt;

    rr_cfg_top #(.REG_STAGES(STAGES)) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // Software model of the byte-strobe merge
    function automatic logic [31:0] merge_word(logic [31:0] old_w, logic [31:0] new_w,
                                               logic [3:0] strb);
        logic [31:0] mask;
        for (int b = 0; b < 4; b++) begin
            mask[8*b +: 8] = strb[b] ? 8'hff : 8'h00;
        end
        return (new_w & mask) | (old_w & ~mask);
    endfunction

    function automatic logic read_only_idx(int idx);
        return idx == 0 || idx >= 12;
    endfunction

    task automatic check_value(string name, logic [63:0] exp_v, logic [63:0] act_v);
        if (exp_v !== act_v) begin
            $display("[FAIL] %s expected %h got %h", name, exp_v, act_v);
            err_cnt++;
        end
    endtask

    // order 0 sends AW and W together, 1 AW first, 2 W first
    task automatic axil_write(int idx, logic [31:0] data, logic [3:0] strb, int order,
                              int gap, int bp);
        int  cyc;
        int  k;
        int  hold;
        int  bcnt;
        bit  aw_done;
        bit  w_done;
        int  aw_start;
        int  w_start;
        aw_start = (order == 2) ? gap + 1 : 0;
        w_start  = (order == 1) ? gap + 1 : 0;
        awaddr_i = idx << 2;
        wdata_i  = data;
        wstrb_i  = strb;
        bready_i = (bp == 0);
        aw_done  = 0;
        w_done   = 0;
        cyc      = 0;
        while (!(aw_done && w_done)) begin
            awvalid_i = !aw_done && cyc >= aw_start;
            wvalid_i  = !w_done && cyc >= w_start;
            @(negedge clk);
            if (awvalid_i && awready_o) aw_done = 1;
            if (wvalid_i && wready_o) w_done = 1;
            @(posedge clk);
            #2;
            cyc++;
            if (cyc > 50) begin
                $display("Write to register %0d was never accepted", idx);
                err_cnt++;
                break;
            end
        end
        awvalid_i = 1'b0;
        wvalid_i  = 1'b0;
        if (!read_only_idx(idx)) begin
            shadow[idx] = merge_word(shadow[idx], data, strb);
        end
        // Now just past the acceptance edge
        k    = 0;
        hold = 0;
        bcnt = 0;
        while (bcnt == 0 || k <= 2 + STAGES) begin
            @(negedge clk);
            if (bvalid_o && bready_i) begin
                bcnt++;
                check_value("bresp_o", 64'd0, {62'd0, bresp_o});
            end
            if (bvalid_o && !bready_i) hold++;
            if (k == 2 + STAGES) begin
                check_value("mode_o", {61'd0, shadow[`RR_CSR_MODE][2:0]}, {61'd0, mode_o});
                check_value("buf_addr_o", {shadow[3], shadow[2]}, buf_addr_o);
                check_value("buf_size_o", {shadow[5], shadow[4]}, buf_size_o);
                check_value("replay_bits_o", {shadow[11], shadow[10]}, replay_bits_o);
            end
            @(posedge clk);
            #2;
            if (hold >= bp) bready_i = 1'b1;
            k++;
            if (k > 60) begin
                $display("No write response for register %0d", idx);
                err_cnt++;
                break;
            end
        end
        @(negedge clk);
        if (bvalid_o) begin
            $display("A second write response appeared for register %0d", idx);
            err_cnt++;
        end
        @(posedge clk);
        #2;
    endtask

    task automatic axil_read(int idx, int bp, output logic [31:0] data);
        int cyc;
        int hold;
        bit got;
        araddr_i  = idx << 2;
        arvalid_i = 1'b1;
        rready_i  = (bp == 0);
        cyc       = 0;
        got       = 0;
        while (!got) begin
            @(negedge clk);
            got = arready_o;
            @(posedge clk);
            #2;
            cyc++;
            if (cyc > 50) begin
                $display("Read of register %0d was never accepted", idx);
                err_cnt++;
                break;
            end
        end
        arvalid_i = 1'b0;
        hold      = 0;
        got       = 0;
        cyc       = 0;
        while (!got) begin
            @(negedge clk);
            if (rvalid_o && rready_i) begin
                got  = 1;
                data = rdata_o;
                check_value("rresp_o", 64'd0, {62'd0, rresp_o});
            end else if (rvalid_o) begin
                hold++;
            end
            @(posedge clk);
            #2;
            if (hold >= bp) rready_i = 1'b1;
            cyc++;
            if (cyc > 50) begin
                $display("No read data for register %0d", idx);
                err_cnt++;
                break;
            end
        end
    endtask

    task automatic read_check(int idx, logic [31:0] exp_v, int bp);
        logic [31:0] data;
        data = 'x;
        axil_read(idx, bp, data);
        check_value($sformatf("rdata_o reg %0d", idx), {32'd0, exp_v}, {32'd0, data});
    endtask

    task automatic send_beats(int n, output logic [63:0] sum);
        sum = 0;
        for (int i = 0; i < n; i++) begin
            trace_valid_i = 1'b1;
            trace_bits_i  = 8'($urandom);
            sum += trace_bits_i;
            @(posedge clk);
            #2;
        end
        trace_valid_i = 1'b0;
        trace_bits_i  = '0;
        repeat (8) @(posedge clk);
        #2;
    endtask

    task automatic check_record_total(logic [63:0] exp_v);
        read_check(`RR_CSR_RECORD_BITS_LO, exp_v[31:0], 0);
        read_check(`RR_CSR_RECORD_BITS_HI, exp_v[63:32], 0);
    endtask

    initial begin
        int          idx;
        int          regs [7];
        logic [63:0] sum;
        regs = '{1, 2, 3, 4, 5, 10, 11};
        void'($urandom(2));
        err_cnt          = 0;
        rstn             = 1'b0;
        awvalid_i        = 1'b0;
        awaddr_i         = '0;
        wvalid_i         = 1'b0;
        wdata_i          = '0;
        wstrb_i          = '0;
        bready_i         = 1'b1;
        arvalid_i        = 1'b0;
        araddr_i         = '0;
        rready_i         = 1'b1;
        trace_valid_i    = 1'b0;
        trace_bits_i     = '0;
        validate_valid_i = 1'b0;
        validate_bits_i  = '0;
        for (int i = 0; i < `RR_CSR_CNT; i++) begin
            shadow[i] = '0;
        end
        shadow[0] = `RR_CSR_VERSION_WORD;
        repeat (3) @(posedge clk);
        #2;
        rstn = 1'b1;
        @(posedge clk);
        #2;

        // Random merges through all three channel orders
        for (int i = 0; i < 18; i++) begin
            idx = regs[$urandom % 7];
            axil_write(idx, $urandom, 4'($urandom), i % 3, i % 2, (i % 5 == 0) ? 3 : 0);
            read_check(idx, shadow[idx], (i % 4 == 0) ? 3 : 0);
        end
        foreach (regs[i]) begin
            read_check(regs[i], shadow[regs[i]], 0);
        end

        // Command pulses
        for (int c = 6; c <= 9; c++) begin
            axil_write(c, $urandom, 4'hf, c % 3, 1, 0);
        end

        // Read-only words
        read_check(`RR_CSR_VERSION, `RR_CSR_VERSION_WORD, 0);
        axil_write(`RR_CSR_VERSION, $urandom, 4'hf, 0, 0, 0);
        read_check(`RR_CSR_VERSION, `RR_CSR_VERSION_WORD, 0);
        axil_write(`RR_CSR_RECORD_BITS_LO, $urandom, 4'hf, 1, 0, 0);
        axil_write(`RR_CSR_VALIDATE_BITS_HI, $urandom, 4'hf, 2, 0, 0);
        check_record_total(64'd0);
        read_check(`RR_CSR_VALIDATE_BITS_HI, 32'd0, 0);

        // Record counting, clear, and disabled beats
        axil_write(`RR_CSR_MODE, 32'h1, 4'hf, 0, 0, 0);
        send_beats(40, sum);
        check_record_total(sum);
        axil_write(`RR_CSR_RECORD_BUF_UPDATE, 32'h1, 4'hf, 0, 0, 0);
        check_record_total(64'd0);
        axil_write(`RR_CSR_MODE, 32'h0, 4'hf, 0, 0, 0);
        send_beats(10, sum);
        check_record_total(64'd0);

        repeat (4) @(posedge clk);
        $display("Errors: %0d checks, %0d assertions", err_cnt, dut_i.u_asserts.fail_cnt);
        if (err_cnt == 0 && dut_i.u_asserts.fail_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog for the whole run
    initial begin
        #2ms;
        $display("Simulation ran past its time limit");
        $display("Test failed");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+logic
logic/rr_csr_pkg.sv
logic/rr_axil_if.sv
logic/rr_pipe.sv
logic/rr_csrs.sv
logic/rr_trace_stats.sv
logic/rr_cfg_top.sv
tb/rr_cfg_asserts.sv
tb/rr_cfg_tb.sv

// File: Makefile
LOG = sim.log

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f vlog.f \
		--top-module rr_cfg_tb -o Vrr_cfg_tb
	./obj_dir/Vrr_cfg_tb +verilator+error+limit+100 | tee $(LOG)
	! grep -q "Test failed" $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
